// File: design/pcFetch_cfg.svh
/*
 * Build-time constants for the fetch subsystem.
 * IMEM_AW must be wide enough to index IMEM_WORDS entries.
 * Register offsets are byte offsets on an 8-bit APB address.
 */
`ifndef PCFETCH_CFG_SVH
`define PCFETCH_CFG_SVH

// every run begins here
`define RESET_PC      32'h0000_0000

// instruction memory geometry
`define IMEM_WORDS    64
`define IMEM_AW       6

// APB register map
`define REG_CTRL      8'h00
`define REG_STATUS    8'h04
`define REG_PC        8'h08
`define REG_LIMIT     8'h0C
`define REG_COUNT     8'h10
`define REG_LOADIDX   8'h14
`define REG_LOADDATA  8'h18

`endif

// File: design/pcFetchPkg.sv
/*
 * Shared types for the fetch subsystem.
 * Opcode encodings sit in instruction bits 31..26; any other value
 * decodes as a sequential instruction.
 */
`default_nettype none

`include "pcFetch_cfg.svh"

package pcFetchPkg;

   typedef logic [31:0] word_t;

   // only the opcodes that steer the next PC
   typedef enum logic [5:0] {
      OP_SEQ    = 6'h00,
      OP_JUMP   = 6'h02,
      OP_BRANCH = 6'h04,
      OP_HALT   = 6'h3F
   } opcode_t;

   typedef enum logic [1:0] {
      ST_IDLE = 2'd0,
      ST_RUN  = 2'd1,
      ST_HALT = 2'd2
   } seqState_t;

   typedef struct packed {
      logic       psel;
      logic       penable;
      logic       pwrite;
      logic [7:0] paddr;
      word_t      pwdata;
   } apbReq_t;

   typedef struct packed {
      word_t prdata;
      logic  pready;
      logic  pslverr;
   } apbRsp_t;

   // host load path into instruction memory
   typedef struct packed {
      logic                en;
      logic [`IMEM_AW-1:0] idx;
      word_t               data;
   } memWrite_t;

   typedef struct packed {
      logic restart;
      logic advance;
   } runCtl_t;

   typedef struct packed {
      logic running;
      logic halted;
   } runStat_t;

endpackage

`default_nettype wire

// File: design/instrMem.sv
/*
 * Instruction memory as a register array.
 * Contents are undefined until loaded over APB.
 * Write at the clock edge, read is combinational.
 */
`timescale 1ns/100ps
`default_nettype none

`include "pcFetch_cfg.svh"

module instrMem
   import pcFetchPkg::*;
(
   input  logic                CLK,
   input  memWrite_t           memWr,
   input  logic [`IMEM_AW-1:0] idx,
   output word_t               instr
);

   word_t mem [`IMEM_WORDS];

   always_ff @(posedge CLK) begin
      if (memWr.en) begin
         mem[memWr.idx] <= memWr.data;
      end
   end

   // asynchronous fetch port
   assign instr = mem[idx];

endmodule

`default_nettype wire

// File: design/apbRegs.sv
/*
 * APB slave with no wait states; pready is tied high.
 * Loads into memory are refused while a run is in progress.
 * PC, COUNT and STATUS are read-only and answer writes with pslverr.
 */
`timescale 1ns/100ps
`default_nettype none

`include "pcFetch_cfg.svh"

module apbRegs
   import pcFetchPkg::*;
(
   input  logic      CLK,
   input  logic      rst,
   input  apbReq_t   apbReq,
   output apbRsp_t   apbRsp,
   input  runStat_t  stat,
   input  word_t     pc,
   input  word_t     count,
   output logic      start,
   output word_t     limit,
   output memWrite_t memWr
);

   logic                access;
   logic                mapped;
   logic                badWrite;
   logic                slvErr;
   logic                wrOk;
   logic [`IMEM_AW-1:0] loadIdx;
   word_t               rdData;

   assign access = apbReq.psel && apbReq.penable;

   // offset decode, readback and per-register write legality
   always_comb begin
      mapped   = 1'b1;
      badWrite = 1'b0;
      rdData   = '0;
      case (apbReq.paddr)
         `REG_CTRL: rdData = '0;
         `REG_STATUS: begin
            rdData   = {30'b0, stat.halted, stat.running};
            badWrite = 1'b1;
         end
         `REG_PC: begin
            rdData   = pc;
            badWrite = 1'b1;
         end
         `REG_LIMIT: rdData = limit;
         `REG_COUNT: begin
            rdData   = count;
            badWrite = 1'b1;
         end
         `REG_LOADIDX: begin
            rdData   = {{(32-`IMEM_AW){1'b0}}, loadIdx};
            badWrite = stat.running;
         end
         // write-only data port
         `REG_LOADDATA: badWrite = stat.running;
         default: mapped = 1'b0;
      endcase
   end

   assign slvErr = access && (!mapped || (apbReq.pwrite && badWrite));
   assign wrOk   = access && apbReq.pwrite && !slvErr;

   assign memWr.en   = wrOk && (apbReq.paddr == `REG_LOADDATA);
   assign memWr.idx  = loadIdx;
   assign memWr.data = apbReq.pwdata;

   assign apbRsp.prdata  = rdData;
   assign apbRsp.pready  = 1'b1;
   assign apbRsp.pslverr = slvErr;

   always_ff @(posedge CLK) begin
      if (rst) begin
         start   <= 1'b0;
         limit   <= '0;
         loadIdx <= '0;
      end else begin
         // registered so the sequencer sees it one cycle after access
         start <= wrOk && (apbReq.paddr == `REG_CTRL) && apbReq.pwdata[0];
         if (wrOk && (apbReq.paddr == `REG_LIMIT)) begin
            limit <= apbReq.pwdata;
         end
         if (wrOk && (apbReq.paddr == `REG_LOADIDX)) begin
            loadIdx <= apbReq.pwdata[`IMEM_AW-1:0];
         end else if (memWr.en) begin
            // auto-increment, wraps at memory depth
            loadIdx <= (loadIdx == `IMEM_AW'(`IMEM_WORDS - 1)) ? '0 : loadIdx + 1'b1;
         end
      end
   end

   // master must hold address and direction across setup and access
   assert property (@(posedge CLK) disable iff (rst)
      (apbReq.psel && !apbReq.penable) |=> $stable(apbReq.paddr) && $stable(apbReq.pwrite))
      else $error("APB paddr or pwrite changed between setup and access");

endmodule

`default_nettype wire

// File: design/fetchSequencer.sv
/*
 * Run control: idle, run, halted.
 * A start in idle or halted restarts from RESET_PC; a start while
 * running is ignored.
 */
`timescale 1ns/100ps
`default_nettype none

module fetchSequencer
   import pcFetchPkg::*;
(
   input  logic     CLK,
   input  logic     rst,
   input  logic     start,
   input  logic     isHalt,
   input  logic     atLimit,
   output runCtl_t  ctl,
   output runStat_t stat
);

   seqState_t state;
   seqState_t nextState;
   logic      stop;

   assign stop = isHalt || atLimit;

   assign ctl.restart = start && (state != ST_RUN);
   assign ctl.advance = (state == ST_RUN);

   assign stat.running = (state == ST_RUN);
   assign stat.halted  = (state == ST_HALT);

   always_comb begin
      nextState = state;
      case (state)
         ST_IDLE,
         ST_HALT: begin
            if (start) begin
               nextState = ST_RUN;
            end
         end
         ST_RUN: begin
            if (stop) begin
               nextState = ST_HALT;
            end
         end
         default: nextState = ST_IDLE;
      endcase
   end

   always_ff @(posedge CLK) begin
      if (rst) begin
         state <= ST_IDLE;
      end else begin
         state <= nextState;
      end
   end

   // fetching only follows a restart or an unstopped run cycle
   assert property (@(posedge CLK) disable iff (rst)
      ctl.advance |-> $past(ctl.restart || (ctl.advance && !stop)))
      else $error("advance raised without a restart or an unstopped run cycle");

endmodule

`default_nettype wire

// File: design/stepCounter.sv
/*
 * Counts retired instructions for the current run.
 * A limit of 0 means unlimited. Lowering the limit below the count
 * mid-run is not supported.
 */
`timescale 1ns/100ps
`default_nettype none

module stepCounter
   import pcFetchPkg::*;
(
   input  logic    CLK,
   input  logic    rst,
   input  runCtl_t ctl,
   input  logic    retire,
   input  word_t   limit,
   output word_t   count,
   output logic    atLimit
);

   assign atLimit = (limit != '0) && (count == limit);

   always_ff @(posedge CLK) begin
      if (rst) begin
         count <= '0;
      end else if (ctl.restart) begin
         count <= '0;
      end else if (retire) begin
         count <= count + 32'd1;
      end
   end

   // retire is gated by atLimit upstream, so the count stops at the limit
   assert property (@(posedge CLK) disable iff (rst)
      (ctl.advance && (limit != '0) && $stable(limit)) |-> (count <= limit))
      else $error("step count %0d passed limit %0d", count, limit);

endmodule

`default_nettype wire

// File: design/progCounter.sv
/*
 * Program counter with just enough decode to choose the next PC.
 * Branches are PC-relative to PC+4; jumps keep the top four bits of PC+4.
 * Unlisted opcodes fall through to PC+4.
 */
`timescale 1ns/100ps
`default_nettype none

`include "pcFetch_cfg.svh"

module progCounter
   import pcFetchPkg::*;
(
   input  logic    CLK,
   input  logic    rst,
   input  runCtl_t ctl,
   input  logic    halting,
   input  word_t   instr,
   output word_t   pc,
   output logic    isHalt,
   output logic    retire
);

   opcode_t op;
   word_t   seqPc;
   word_t   branchPc;
   word_t   jumpPc;
   word_t   nextPc;

   assign op = opcode_t'(instr[31:26]);

   assign seqPc    = pc + 32'd4;
   // sign-extended word offset
   assign branchPc = seqPc + {{14{instr[15]}}, instr[15:0], 2'b00};
   assign jumpPc   = {seqPc[31:28], instr[25:0], 2'b00};

   always_comb begin
      case (op)
         OP_BRANCH: nextPc = branchPc;
         OP_JUMP:   nextPc = jumpPc;
         default:   nextPc = seqPc;
      endcase
   end

   assign isHalt = (op == OP_HALT);

   // halt words and the limit-hit cycle are not retired
   assign retire = ctl.advance && !halting;

   always_ff @(posedge CLK) begin
      if (rst) begin
         pc <= `RESET_PC;
      end else if (ctl.restart) begin
         pc <= `RESET_PC;
      end else if (retire) begin
         pc <= nextPc;
      end
   end

   assert property (@(posedge CLK) disable iff (rst) pc[1:0] == 2'b00)
      else $error("PC %h not word aligned", pc);

endmodule

`default_nettype wire

// File: design/pcFetchTop.sv
/*
 * Instruction-fetch subsystem top level.
 * Memory is indexed by PC bits 7..2, so far targets alias into it.
 * fetchValid marks each retired word; done is high while halted.
 */
`timescale 1ns/100ps
`default_nettype none

`include "pcFetch_cfg.svh"

module pcFetchTop
   import pcFetchPkg::*;
(
   input  logic    CLK,
   input  logic    rst,
   input  apbReq_t apbReq,
   output apbRsp_t apbRsp,
   output word_t   fetchAddr,
   output logic    fetchValid,
   output logic    done
);

   runCtl_t   ctl;
   runStat_t  stat;
   memWrite_t memWr;
   word_t     pc;
   word_t     count;
   word_t     limit;
   word_t     instr;
   logic      start;
   logic      isHalt;
   logic      atLimit;
   logic      halting;
   logic      retire;

   // single stop condition for the PC
   assign halting = isHalt || atLimit;

   apbRegs regs (
      .CLK    (CLK),
      .rst    (rst),
      .apbReq (apbReq),
      .apbRsp (apbRsp),
      .stat   (stat),
      .pc     (pc),
      .count  (count),
      .start  (start),
      .limit  (limit),
      .memWr  (memWr)
   );

   fetchSequencer seq (
      .CLK     (CLK),
      .rst     (rst),
      .start   (start),
      .isHalt  (isHalt),
      .atLimit (atLimit),
      .ctl     (ctl),
      .stat    (stat)
   );

   stepCounter steps (
      .CLK     (CLK),
      .rst     (rst),
      .ctl     (ctl),
      .retire  (retire),
      .limit   (limit),
      .count   (count),
      .atLimit (atLimit)
   );

   progCounter pcReg (
      .CLK     (CLK),
      .rst     (rst),
      .ctl     (ctl),
      .halting (halting),
      .instr   (instr),
      .pc      (pc),
      .isHalt  (isHalt),
      .retire  (retire)
   );

   instrMem imem (
      .CLK   (CLK),
      .memWr (memWr),
      .idx   (pc[`IMEM_AW+1:2]),
      .instr (instr)
   );

   assign fetchAddr  = pc;
   assign fetchValid = retire;
   assign done       = stat.halted;

endmodule

`default_nettype wire

// File: verif/pcFetchTbTasks.svh
/*
 * APB transfer tasks and the reference fetch model.
 * Included inside pcFetchTb; uses its clock, APB signals and model state.
 * The model indexes memory by PC bits 7..2, like the hardware.
 */
`ifndef PCFETCH_TB_TASKS_SVH
`define PCFETCH_TB_TASKS_SVH

// setup on one falling edge and access on the next
task automatic apbTransfer(input logic wr, input logic [7:0] addr, input word_t wdata,
                           output word_t rdata, output logic err);
   @(negedge CLK);
   apbReq.psel    = 1'b1;
   apbReq.penable = 1'b0;
   apbReq.pwrite  = wr;
   apbReq.paddr   = addr;
   apbReq.pwdata  = wdata;
   @(negedge CLK);
   apbReq.penable = 1'b1;
   // response settles well before the access edge
   #SETTLE;
   rdata = apbRsp.prdata;
   err   = apbRsp.pslverr;
   assert (apbRsp.pready)
      else showMismatch("pready", 32'd1, 32'(apbRsp.pready));
   @(negedge CLK);
   apbReq = '0;
endtask

task automatic writeReg(input logic [7:0] addr, input word_t data);
   word_t rd;
   logic  err;
   apbTransfer(1'b1, addr, data, rd, err);
   assert (!err)
      else abortWith($sformatf("pslverr on write to offset %h", addr));
endtask

task automatic readReg(input logic [7:0] addr, output word_t data);
   logic err;
   apbTransfer(1'b0, addr, 32'd0, data, err);
   assert (!err)
      else abortWith($sformatf("pslverr on read of offset %h", addr));
endtask

function automatic word_t nextPcOf(input word_t pc, input word_t w);
   word_t link;
   word_t offset;
   link   = pc + 32'd4;
   offset = {{16{w[15]}}, w[15:0]};
   case (w[31:26])
      OP_BRANCH: return link + (offset << 2);
      OP_JUMP:   return (link & 32'hF000_0000) | (32'(w[25:0]) << 2);
      default:   return link;
   endcase
endfunction

// fills expTrace with every retired PC and stops at halt, limit or FREE_STEPS
task automatic modelRun(input word_t limit, output bit finished);
   word_t       pc;
   word_t       w;
   int unsigned steps;
   expTrace.delete();
   pc       = `RESET_PC;
   steps    = 0;
   finished = 1'b0;
   while (!finished && steps <= FREE_STEPS) begin
      w = modelMem[pc[7:2]];
      if ((limit != 0 && steps == limit) || w[31:26] == OP_HALT) begin
         finished = 1'b1;
      end else begin
         expTrace.push_back(pc);
         pc = nextPcOf(pc, w);
         steps++;
      end
   end
   modelPc    = pc;
   modelCount = steps;
endtask

`endif

// File: verif/pcFetchTb.sv
/*
 * Testbench for the fetch subsystem.
 * Random programs are checked against a model of the next-PC rules.
 * Stops at the first mismatch; a cycle budget guards against hangs.
 */
`timescale 1ns/100ps
`default_nettype none

`include "pcFetch_cfg.svh"

module pcFetchTb
   import pcFetchPkg::*;
();

   localparam int SETTLE     = 10;
   localparam int NUM_RANDOM = 12;
   localparam int MAX_LIMIT  = 120;
   localparam int FREE_STEPS = 300;
   // random runs plus three directed ones that each take a full load and a long run
   localparam int NUM_RUNS   = NUM_RANDOM + 3;
   localparam int unsigned TIMEOUT_CYCLES =
      20 * NUM_RUNS * (`IMEM_WORDS + FREE_STEPS) + 2000;

   logic    CLK;
   logic    rst;
   apbReq_t apbReq;
   apbRsp_t apbRsp;
   word_t   fetchAddr;
   logic    fetchValid;
   logic    done;

   word_t       modelMem [`IMEM_WORDS];
   word_t       expTrace [$];
   word_t       modelPc;
   word_t       modelCount;
   int unsigned retiredCount;
   int unsigned cycles = 0;

   pcFetchTop uut (
      .CLK        (CLK),
      .rst        (rst),
      .apbReq     (apbReq),
      .apbRsp     (apbRsp),
      .fetchAddr  (fetchAddr),
      .fetchValid (fetchValid),
      .done       (done)
   );

   `include "pcFetchTbTasks.svh"

   initial begin
      CLK = 1'b0;
      forever #50 CLK = ~CLK;
   end

   task automatic showMismatch(input string sig, input word_t exp, input word_t act);
      $display("FAIL time=%0t %s expected %h got %h", $time, sig, exp, act);
      $display("Test failed");
      $fatal(1, "value mismatch");
   endtask

   task automatic abortWith(input string what);
      $display("Error at time %0t: %s", $time, what);
      $display("Test failed");
      $fatal(1, "check failed");
   endtask

   function automatic word_t makeInstr();
      int unsigned pick;
      logic [5:0]  op;
      logic [15:0] off;
      logic [25:0] target;
      pick   = $urandom % 100;
      op     = 6'($urandom);
      off    = 16'($urandom % 13) - 16'd6;
      // mostly near targets and sometimes far ones that alias
      target = (($urandom % 8) == 0) ? 26'($urandom) : 26'($urandom % 64);
      if (pick < 6) begin
         return {OP_HALT, 26'($urandom)};
      end else if (pick < 26) begin
         return {OP_BRANCH, 10'($urandom), off};
      end else if (pick < 38) begin
         return {OP_JUMP, target};
      end
      if (op == OP_JUMP || op == OP_BRANCH || op == OP_HALT) begin
         op = OP_SEQ;
      end
      return {op, 26'($urandom)};
   endfunction

   task automatic loadProgram();
      writeReg(`REG_LOADIDX, 32'd0);
      for (int i = 0; i < `IMEM_WORDS; i++) begin
         writeReg(`REG_LOADDATA, modelMem[i[`IMEM_AW-1:0]]);
      end
   endtask

   // returns in the first run cycle
   task automatic startRun(input word_t limit, input bit checkLatency);
      writeReg(`REG_LIMIT, limit);
      retiredCount = 0;
      writeReg(`REG_CTRL, 32'd1);
      // now in the restart cycle
      if (checkLatency) begin
         assert (!fetchValid)
            else showMismatch("fetchValid", 32'd0, 32'(fetchValid));
      end
      @(negedge CLK);
      assert (!done)
         else abortWith("start write did not leave the halted state");
      if (checkLatency) begin
         assert (fetchValid)
            else abortWith("first fetchValid not 2 cycles after the start access");
         assert (fetchAddr == `RESET_PC)
            else showMismatch("fetchAddr", `RESET_PC, fetchAddr);
      end
   endtask

   task automatic finishRun(input word_t limit);
      word_t rd;
      while (!done) @(negedge CLK);
      assert (retiredCount == modelCount)
         else showMismatch("retired words", modelCount, retiredCount);
      readReg(`REG_PC, rd);
      assert (rd == modelPc) else showMismatch("PC", modelPc, rd);
      readReg(`REG_COUNT, rd);
      assert (limit == 0 || rd <= limit)
         else abortWith($sformatf("COUNT %0d passed the step limit %0d", rd, limit));
      assert (rd == modelCount) else showMismatch("COUNT", modelCount, rd);
      readReg(`REG_STATUS, rd);
      assert (rd == 32'h2) else showMismatch("STATUS", 32'h2, rd);
   endtask

   // every retired word against the expected trace
   always @(negedge CLK) begin
      if (!rst && fetchValid) begin
         assert (expTrace.size() > 0)
            else abortWith("fetchValid with no fetch left in the expected trace");
         assert (fetchAddr == expTrace[0])
            else showMismatch("fetchAddr", expTrace[0], fetchAddr);
         void'(expTrace.pop_front());
         retiredCount++;
      end
   end

   always @(posedge CLK) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Test failed");
         $fatal(1, "cycle limit reached");
      end
   end

   initial begin
      logic  err;
      word_t rd;
      word_t lim;
      bit    finished;
      rst    = 1'b1;
      apbReq = '0;
      void'($urandom(32'h5da2));
      repeat (4) @(negedge CLK);
      rst = 1'b0;

      assert (!fetchValid && !done)
         else abortWith("fetchValid or done high after reset");
      readReg(`REG_PC, rd);
      assert (rd == `RESET_PC) else showMismatch("PC", `RESET_PC, rd);
      readReg(`REG_COUNT, rd);
      assert (rd == 32'd0) else showMismatch("COUNT", 32'd0, rd);
      readReg(`REG_STATUS, rd);
      assert (rd == 32'd0) else showMismatch("STATUS", 32'd0, rd);

      // straight-line code with a halt at word 20
      for (int i = 0; i < `IMEM_WORDS; i++) begin
         if (i < 20) begin
            modelMem[i[`IMEM_AW-1:0]] = {OP_SEQ, 26'(i)};
         end else if (i == 20) begin
            modelMem[i[`IMEM_AW-1:0]] = {OP_HALT, 26'd0};
         end else begin
            modelMem[i[`IMEM_AW-1:0]] = makeInstr();
         end
      end
      loadProgram();
      expTrace.delete();
      for (int i = 0; i < 20; i++) begin
         expTrace.push_back(32'(i) * 32'd4);
      end
      modelPc    = 32'd80;
      modelCount = 32'd20;
      startRun(32'd0, 1'b0);
      finishRun(32'd0);

      // restart from halted with a limit
      modelRun(32'd7, finished);
      startRun(32'd7, 1'b1);
      finishRun(32'd7);

      for (int r = 0; r < NUM_RANDOM; r++) begin
         for (int i = 0; i < `IMEM_WORDS; i++) begin
            modelMem[i[`IMEM_AW-1:0]] = makeInstr();
         end
         loadProgram();
         lim = (($urandom % 3) == 0) ? 32'd0 : 32'(1 + ($urandom % MAX_LIMIT));
         modelRun(lim, finished);
         if (!finished) begin
            // program loops forever so a limit bounds it instead
            lim = 32'(1 + ($urandom % MAX_LIMIT));
            modelRun(lim, finished);
         end
         startRun(lim, 1'b0);
         finishRun(lim);
      end

      // refused accesses in the middle of a 40 step run
      for (int i = 0; i < `IMEM_WORDS; i++) begin
         modelMem[i[`IMEM_AW-1:0]] = {OP_SEQ, 26'(i * 5)};
      end
      loadProgram();
      writeReg(`REG_LOADIDX, 32'd30);
      modelRun(32'd40, finished);
      startRun(32'd40, 1'b0);
      apbTransfer(1'b1, `REG_LOADDATA, {OP_HALT, 26'd0}, rd, err);
      assert (err) else abortWith("LOADDATA write accepted while running");
      readReg(`REG_LOADIDX, rd);
      assert (rd == 32'd30) else showMismatch("LOADIDX", 32'd30, rd);
      apbTransfer(1'b1, 8'h1C, 32'hA5A5_A5A5, rd, err);
      assert (err) else abortWith("write to an unmapped offset gave no pslverr");
      apbTransfer(1'b0, 8'h1C, 32'd0, rd, err);
      assert (err) else abortWith("read of an unmapped offset gave no pslverr");
      apbTransfer(1'b1, `REG_COUNT, 32'h0000_FFFF, rd, err);
      assert (err) else abortWith("write to COUNT gave no pslverr");
      readReg(`REG_LIMIT, rd);
      assert (rd == 32'd40) else showMismatch("LIMIT", 32'd40, rd);
      finishRun(32'd40);

      $display("Test passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: pcFetch.f
+incdir+design
+incdir+verif
design/pcFetchPkg.sv
design/instrMem.sv
design/apbRegs.sv
design/fetchSequencer.sv
design/stepCounter.sv
design/progCounter.sv
design/pcFetchTop.sv
verif/pcFetchTb.sv

// File: Makefile
# Verilator build and run for the fetch subsystem testbench

SIM = obj_dir/VpcFetchTb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 --top-module pcFetchTb -f pcFetch.f

# passes only when the simulation prints the pass line
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir
